// File: logic/vcache_mon_if.sv
interface vcache_mon_if import vcache_pkg::*; ();

  logic        retire_v;                       // response handshake this cycle
  vcache_cls_e retire_cls;
  logic        retire_miss;
  logic        miss_v;                         // miss stall cycle

  modport tag (
    output retire_v,
    output retire_cls,
    output retire_miss,
    output miss_v
  );

  modport prof (
    input retire_v,
    input retire_cls,
    input retire_miss,
    input miss_v
  );

endinterface

// File: logic/vcache_pkg.sv
package vcache_pkg;

  localparam int ADDR_W    = 12;
  localparam int OFFSET_W  = 3;                // byte offset within a line
  localparam int INDEX_W   = 3;
  localparam int TAG_W     = ADDR_W - INDEX_W - OFFSET_W;
  localparam int NUM_SETS  = 8;
  localparam int NUM_STATS = 16;

  localparam int MISS_CYCLES = 4;              // stall length of one miss
  localparam int MISS_CNT_W  = $clog2(MISS_CYCLES + 1);
  localparam int FIFO_DEPTH  = 4;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [3:0]         mask_t;
  typedef logic [1:0]         size_t;          // 0 byte, 1 half, 2/3 word
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [31:0]        stat_count_t;
  typedef logic [3:0]         stat_sel_t;

  typedef enum logic [1:0] {
    OP_LD    = 2'd0,
    OP_ST    = 2'd1,
    OP_TAGFL = 2'd2,                           // invalidate all lines
    OP_AINV  = 2'd3                            // invalidate line of addr
  } vcache_op_e;

  typedef enum logic [3:0] {
    CLS_LD_W, CLS_LD_H, CLS_LD_HU, CLS_LD_B, CLS_LD_BU,
    CLS_ST_W, CLS_ST_H, CLS_ST_B, CLS_ST_OTHER,
    CLS_TAGFL, CLS_AINV
  } vcache_cls_e;

  // counter select codes
  localparam stat_sel_t STAT_LD     = 4'd0;
  localparam stat_sel_t STAT_LD_LW  = 4'd1;
  localparam stat_sel_t STAT_LD_LH  = 4'd2;
  localparam stat_sel_t STAT_LD_LHU = 4'd3;
  localparam stat_sel_t STAT_LD_LB  = 4'd4;
  localparam stat_sel_t STAT_LD_LBU = 4'd5;
  localparam stat_sel_t STAT_ST     = 4'd6;
  localparam stat_sel_t STAT_ST_SW  = 4'd7;
  localparam stat_sel_t STAT_ST_SH  = 4'd8;
  localparam stat_sel_t STAT_ST_SB  = 4'd9;
  localparam stat_sel_t STAT_TAGFL  = 4'd10;
  localparam stat_sel_t STAT_AINV   = 4'd11;
  localparam stat_sel_t STAT_MISS_LD     = 4'd12;
  localparam stat_sel_t STAT_MISS_ST     = 4'd13;
  localparam stat_sel_t STAT_MISS_CYCLES = 4'd14;
  localparam stat_sel_t STAT_IDLE_CYCLES = 4'd15;

endpackage

// File: logic/vcache_profiled.sv
module vcache_profiled import vcache_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,

  input  logic        req_v_i,
  input  vcache_op_e  req_op_i,
  input  size_t       req_size_i,
  input  logic        req_sigext_i,
  input  mask_t       req_mask_i,
  input  addr_t       req_addr_i,
  output logic        req_ready_o,

  output logic        resp_v_o,
  input  logic        resp_ready_i,
  output vcache_cls_e resp_cls_o,
  output logic        resp_miss_o,

  input  stat_sel_t   stat_sel_i,
  output stat_count_t stat_o
);

  vcache_req_if dec_to_fifo ();                // decoder slot to FIFO
  vcache_req_if fifo_to_tag ();
  vcache_mon_if mon ();                        // profiler events

  vcache_req_decode u_decode (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_v_i      (req_v_i),
    .in_op_i     (req_op_i),
    .in_size_i   (req_size_i),
    .in_sigext_i (req_sigext_i),
    .in_mask_i   (req_mask_i),
    .in_addr_i   (req_addr_i),
    .in_ready_o  (req_ready_o),
    .out_o       (dec_to_fifo.src)
  );

  vcache_req_fifo #(
    .depth (FIFO_DEPTH)
  ) u_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .in_i    (dec_to_fifo.snk),
    .out_o   (fifo_to_tag.src)
  );

  vcache_tag_stage u_tag (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (fifo_to_tag.snk),
    .resp_v_o     (resp_v_o),
    .resp_ready_i (resp_ready_i),
    .resp_cls_o   (resp_cls_o),
    .resp_miss_o  (resp_miss_o),
    .mon_o        (mon.tag)
  );

  vcache_profiler u_prof (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .mon_i      (mon.prof),
    .stat_sel_i (stat_sel_i),
    .stat_o     (stat_o)
  );

endmodule

// File: logic/vcache_profiler.sv
module vcache_profiler import vcache_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  vcache_mon_if.prof  mon_i,
  input  stat_sel_t   stat_sel_i,
  output stat_count_t stat_o
);

  stat_count_t          cnt_r [NUM_STATS];
  logic [NUM_STATS-1:0] inc;
  logic                 is_ld;
  logic                 is_st;

  assign is_ld = mon_i.retire_cls inside {CLS_LD_W, CLS_LD_H, CLS_LD_HU, CLS_LD_B,
                                          CLS_LD_BU};
  assign is_st = mon_i.retire_cls inside {CLS_ST_W, CLS_ST_H, CLS_ST_B, CLS_ST_OTHER};

  // one increment strobe per counter
  always_comb begin
    inc = '0;
    if (mon_i.retire_v) begin
      case (mon_i.retire_cls)
        CLS_LD_W:  inc[STAT_LD_LW]  = 1'b1;
        CLS_LD_H:  inc[STAT_LD_LH]  = 1'b1;
        CLS_LD_HU: inc[STAT_LD_LHU] = 1'b1;
        CLS_LD_B:  inc[STAT_LD_LB]  = 1'b1;
        CLS_LD_BU: inc[STAT_LD_LBU] = 1'b1;
        CLS_ST_W:  inc[STAT_ST_SW]  = 1'b1;
        CLS_ST_H:  inc[STAT_ST_SH]  = 1'b1;
        CLS_ST_B:  inc[STAT_ST_SB]  = 1'b1;
        CLS_TAGFL: inc[STAT_TAGFL]  = 1'b1;
        CLS_AINV:  inc[STAT_AINV]   = 1'b1;
        default:   inc = '0;                   // odd-mask store, STAT_ST only
      endcase
      inc[STAT_LD] = is_ld;
      inc[STAT_ST] = is_st;
      inc[STAT_MISS_LD] = is_ld & mon_i.retire_miss;
      inc[STAT_MISS_ST] = is_st & mon_i.retire_miss;
    end
    inc[STAT_MISS_CYCLES] = mon_i.miss_v;
    inc[STAT_IDLE_CYCLES] = ~mon_i.miss_v & ~mon_i.retire_v;   // neither stalled nor retiring
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_STATS; i++) begin
      if (reset_i) begin
        cnt_r[i] <= '0;
      end else if (inc[i]) begin
        cnt_r[i] <= cnt_r[i] + 1'b1;
      end
    end
  end

  assign stat_o = cnt_r[stat_sel_i];           // readout mux

  a_retire_not_in_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    !(mon_i.retire_v && mon_i.miss_v));

endmodule

// File: logic/vcache_req_decode.sv
module vcache_req_decode import vcache_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       in_v_i,
  input  vcache_op_e in_op_i,
  input  size_t      in_size_i,
  input  logic       in_sigext_i,
  input  mask_t      in_mask_i,
  input  addr_t      in_addr_i,
  output logic       in_ready_o,
  vcache_req_if.src  out_o
);

  function automatic vcache_cls_e classify(vcache_op_e op, size_t size, logic sigext,
                                           mask_t mask);
    vcache_cls_e cls;
    case (op)
      OP_LD: begin
        if (size[1]) cls = CLS_LD_W;           // word ignores sign flag
        else if (size[0]) cls = sigext ? CLS_LD_H : CLS_LD_HU;
        else cls = sigext ? CLS_LD_B : CLS_LD_BU;
      end
      OP_ST: begin
        case ($countones(mask))
          4:       cls = CLS_ST_W;
          2:       cls = CLS_ST_H;
          1:       cls = CLS_ST_B;
          default: cls = CLS_ST_OTHER;         // odd masks
        endcase
      end
      OP_TAGFL: cls = CLS_TAGFL;
      default:  cls = CLS_AINV;
    endcase
    return cls;
  endfunction

  logic        slot_v_r;
  vcache_cls_e cls_r;
  addr_t       addr_r;

  assign in_ready_o  = ~slot_v_r | out_o.ready;   // empty or draining
  assign out_o.valid = slot_v_r;
  assign out_o.cls   = cls_r;
  assign out_o.addr  = addr_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_v_r <= 1'b0;
    end else if (in_v_i && in_ready_o) begin
      slot_v_r <= 1'b1;
    end else if (out_o.ready) begin
      slot_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_v_i && in_ready_o) begin
      cls_r  <= classify(in_op_i, in_size_i, in_sigext_i, in_mask_i);
      addr_r <= in_addr_i;
    end
  end

  a_hold_until_taken: assert property (@(posedge clk_i) disable iff (reset_i)
    out_o.valid && !out_o.ready |=> out_o.valid && $stable(out_o.cls) && $stable(out_o.addr));

endmodule

// File: logic/vcache_req_fifo.sv
module vcache_req_fifo import vcache_pkg::*; #(
  parameter int depth = FIFO_DEPTH             // power of two
) (
  input logic       clk_i,
  input logic       reset_i,
  vcache_req_if.snk in_i,
  vcache_req_if.src out_o
);

  localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
  localparam int CNT_W = $clog2(depth + 1);

  vcache_cls_e cls_mem  [depth];
  addr_t       addr_mem [depth];

  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             push;
  logic             pop;

  assign in_i.ready  = (count_r != CNT_W'(depth));   // full drops ready
  assign out_o.valid = (count_r != '0);
  assign out_o.cls   = cls_mem[rd_ptr_r];
  assign out_o.addr  = addr_mem[rd_ptr_r];

  assign push = in_i.valid & in_i.ready;
  assign pop  = out_o.valid & out_o.ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == PTR_W'(depth - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == PTR_W'(depth - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;           // none or both
      endcase
    end
  end

  // storage, written only on push
  always_ff @(posedge clk_i) begin
    if (push) begin
      cls_mem[wr_ptr_r]  <= in_i.cls;
      addr_mem[wr_ptr_r] <= in_i.addr;
    end
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    count_r <= CNT_W'(depth));

endmodule

// File: logic/vcache_req_if.sv
interface vcache_req_if import vcache_pkg::*; ();

  logic        valid;
  logic        ready;
  vcache_cls_e cls;                            // profiling class
  addr_t       addr;

  // producer side
  modport src (
    output valid,
    output cls,
    output addr,
    input  ready
  );

  // consumer side
  modport snk (
    input  valid,
    input  cls,
    input  addr,
    output ready
  );

endinterface

// File: logic/vcache_tag_stage.sv
module vcache_tag_stage import vcache_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  vcache_req_if.snk   req_i,
  output logic        resp_v_o,
  input  logic        resp_ready_i,
  output vcache_cls_e resp_cls_o,
  output logic        resp_miss_o,
  vcache_mon_if.tag   mon_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MISS,
    ST_RESP
  } state_e;

  state_e                state_r;
  logic [NUM_SETS-1:0]   valid_r;
  tag_t                  tag_r [NUM_SETS];

  vcache_cls_e           cls_r;
  addr_t                 addr_r;
  logic                  miss_r;
  logic [MISS_CNT_W-1:0] miss_cnt_r;

  index_t req_idx;
  tag_t   req_tag;
  index_t held_idx;
  logic   take;
  logic   hit;
  logic   is_mem;

  assign req_idx  = req_i.addr[OFFSET_W +: INDEX_W];
  assign req_tag  = req_i.addr[OFFSET_W + INDEX_W +: TAG_W];
  assign held_idx = addr_r[OFFSET_W +: INDEX_W];

  assign req_i.ready = (state_r == ST_IDLE);   // one request in flight
  assign take   = req_i.valid & req_i.ready;
  assign hit    = valid_r[req_idx] && (tag_r[req_idx] == req_tag);
  assign is_mem = (req_i.cls != CLS_TAGFL) && (req_i.cls != CLS_AINV);

  assign resp_v_o    = (state_r == ST_RESP);
  assign resp_cls_o  = cls_r;
  assign resp_miss_o = miss_r;

  assign mon_o.retire_v    = resp_v_o & resp_ready_i;
  assign mon_o.retire_cls  = cls_r;
  assign mon_o.retire_miss = miss_r;
  assign mon_o.miss_v      = (state_r == ST_MISS);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ST_IDLE;
      valid_r <= '0;                           // all lines invalid
    end else begin
      case (state_r)
        ST_IDLE: begin
          if (take) begin
            case (req_i.cls)
              CLS_TAGFL: begin
                valid_r <= '0;
                state_r <= ST_RESP;
              end
              CLS_AINV: begin
                if (hit) valid_r[req_idx] <= 1'b0;   // only on tag match
                state_r <= ST_RESP;
              end
              default: state_r <= hit ? ST_RESP : ST_MISS;
            endcase
          end
        end
        ST_MISS: begin
          if (miss_cnt_r == '0) begin
            valid_r[held_idx] <= 1'b1;         // allocate at end of stall
            state_r <= ST_RESP;
          end
        end
        ST_RESP: if (resp_ready_i) state_r <= ST_IDLE;
        default: state_r <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      cls_r      <= req_i.cls;
      addr_r     <= req_i.addr;
      miss_r     <= is_mem & ~hit;
      miss_cnt_r <= MISS_CNT_W'(MISS_CYCLES - 1);
    end else if (state_r == ST_MISS) begin
      miss_cnt_r <= miss_cnt_r - 1'b1;
      if (miss_cnt_r == '0) tag_r[held_idx] <= addr_r[OFFSET_W + INDEX_W +: TAG_W];
    end
  end

  a_resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_cls_o) && $stable(resp_miss_o));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f vcache_profiled.f --top-module vcache_profiled_tb -o vcache_sim \
  && ./obj_dir/vcache_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0

// File: tests/vcache_profiled_tb.sv
module vcache_profiled_tb import vcache_pkg::*; ();

  localparam int TOTAL_REQS  = 169;
  localparam int CYCLE_LIMIT = TOTAL_REQS * (MISS_CYCLES + 4) * 2 + 200;

  logic clk_i, reset_i, req_v_i, req_sigext_i, req_ready_o;
  vcache_op_e  req_op_i;
  size_t       req_size_i;
  mask_t       req_mask_i;
  addr_t       req_addr_i;
  logic        resp_v_o, resp_ready_i, resp_miss_o;
  vcache_cls_e resp_cls_o;
  stat_sel_t   stat_sel_i;
  stat_count_t stat_o;

  // reference model state
  logic        mdl_valid [NUM_SETS];
  tag_t        mdl_tag   [NUM_SETS];
  stat_count_t mdl_cnt   [NUM_STATS];
  vcache_cls_e exp_cls_q [$];
  logic        exp_miss_q [$];
  int miss_total, req_cnt, resp_cnt, edge_cnt, cycles, errors, checks;
  logic stall_on, bp_on, drop_seen;
  logic ready_nxt;

  vcache_profiled UUT (.*);

  always #5 clk_i = ~clk_i;

  function automatic vcache_cls_e model_class(vcache_op_e op, size_t sz, logic sx, mask_t m);
    int ones;
    ones = 0;
    for (int i = 0; i < 4; i++) if (m[i]) ones++;
    if (op == OP_TAGFL) return CLS_TAGFL;
    if (op == OP_AINV) return CLS_AINV;
    if (op == OP_ST) return (ones == 4) ? CLS_ST_W : (ones == 2) ? CLS_ST_H :
                            (ones == 1) ? CLS_ST_B : CLS_ST_OTHER;
    if (sz == 2'd0) return sx ? CLS_LD_B : CLS_LD_BU;
    if (sz == 2'd1) return sx ? CLS_LD_H : CLS_LD_HU;
    return CLS_LD_W;
  endfunction

  task automatic bump(input stat_sel_t sel);
    mdl_cnt[sel] = mdl_cnt[sel] + 1;
  endtask

  // applies one accepted request to the model in request order
  task automatic model_accept(input vcache_op_e op, input size_t sz, input logic sx,
                              input mask_t m, input addr_t a);
    vcache_cls_e c;
    index_t idx;
    tag_t   t;
    logic   match, miss, is_ld;
    c = model_class(op, sz, sx, m);
    idx = a[5:3];
    t = a[11:6];
    match = mdl_valid[idx] && (mdl_tag[idx] == t);
    miss = 1'b0;
    is_ld = c inside {CLS_LD_W, CLS_LD_H, CLS_LD_HU, CLS_LD_B, CLS_LD_BU};
    case (c)
      CLS_TAGFL: begin
        for (int s = 0; s < NUM_SETS; s++) mdl_valid[s] = 1'b0;
        bump(STAT_TAGFL);
      end
      CLS_AINV: begin
        if (match) mdl_valid[idx] = 1'b0;    // wrong tag leaves the line alone
        bump(STAT_AINV);
      end
      default: begin
        miss = !match;
        mdl_valid[idx] = 1'b1;
        mdl_tag[idx] = t;
        bump(is_ld ? STAT_LD : STAT_ST);
        if (miss) bump(is_ld ? STAT_MISS_LD : STAT_MISS_ST);
        if (miss) miss_total++;
        case (c)
          CLS_LD_W:  bump(STAT_LD_LW);
          CLS_LD_H:  bump(STAT_LD_LH);
          CLS_LD_HU: bump(STAT_LD_LHU);
          CLS_LD_B:  bump(STAT_LD_LB);
          CLS_LD_BU: bump(STAT_LD_LBU);
          CLS_ST_W:  bump(STAT_ST_SW);
          CLS_ST_H:  bump(STAT_ST_SH);
          CLS_ST_B:  bump(STAT_ST_SB);
          default:   ;                       // odd mask has no own counter
        endcase
      end
    endcase
    exp_cls_q.push_back(c);
    exp_miss_q.push_back(miss);
  endtask

  task automatic check_cls(input vcache_cls_e got, input vcache_cls_e exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t: %s class %s, expected %s", $time, what, got.name(),
               exp.name());
    end
  endtask

  task automatic check_miss(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t: %s miss %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input stat_count_t got, input stat_count_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic send_req(input vcache_op_e op, input size_t sz, input logic sx,
                          input mask_t m, input addr_t a);
    req_v_i = 1'b1;
    req_op_i = op;
    req_size_i = sz;
    req_sigext_i = sx;
    req_mask_i = m;
    req_addr_i = a;
    do @(negedge clk_i); while (!req_ready_o);   // handshake at the next edge
    model_accept(op, sz, sx, m, a);
    req_cnt++;
    @(posedge clk_i);
    #1 req_v_i = 1'b0;
  endtask

  task automatic send_rand(input logic mem_only);
    vcache_op_e op;
    int r;
    r = $urandom % 16;
    if (mem_only) op = r[0] ? OP_ST : OP_LD;
    else if (r < 7) op = OP_LD;
    else if (r < 14) op = OP_ST;
    else op = (r == 14) ? OP_TAGFL : OP_AINV;
    // tags 0..3 only so lines get reused
    send_req(op, size_t'($urandom % 4), logic'($urandom % 2), mask_t'($urandom % 16),
             addr_t'($urandom % 256));
  endtask

  task automatic drain();
    while (resp_cnt != req_cnt) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic do_reset();
    reset_i = 1'b1;
    repeat (16) @(posedge clk_i);
    #1;
    for (int s = 0; s < NUM_SETS; s++) mdl_valid[s] = 1'b0;
    for (int s = 0; s < NUM_STATS; s++) mdl_cnt[s] = '0;
    miss_total = 0;
    req_cnt = 0;
    resp_cnt = 0;
    edge_cnt = 0;
    reset_i = 1'b0;
  endtask

  task automatic check_events();
    for (int s = STAT_LD; s <= STAT_MISS_ST; s++) begin
      stat_sel_i = stat_sel_t'(s);
      #1 check_count(stat_o, mdl_cnt[s], $sformatf("counter %0d", s));
    end
    @(posedge clk_i);
    #1;
  endtask

  // called right after a rising edge so all reads fall in one cycle
  task automatic check_cycles();
    stat_count_t mc, ic;
    stat_sel_i = STAT_MISS_CYCLES;
    #1 mc = stat_o;
    stat_sel_i = STAT_IDLE_CYCLES;
    #1 ic = stat_o;
    check_count(mc, stat_count_t'(MISS_CYCLES * miss_total), "miss cycles");
    check_count(mc + ic + stat_count_t'(resp_cnt), stat_count_t'(edge_cnt), "cycle sum");
  endtask

  task automatic test_done(input string name, input int errs_before);
    $display("%s: %s", name, (errors == errs_before) ? "ok" : "failed");
  endtask

  // responses and cycle bookkeeping sampled mid-cycle
  always @(negedge clk_i) begin
    if (!reset_i) begin
      edge_cnt++;
      if (resp_v_o && resp_ready_i) begin
        resp_cnt++;
        if (exp_cls_q.size() == 0) begin
          errors++;
          $display("response at %0t with no request outstanding", $time);
        end else begin
          check_cls(resp_cls_o, exp_cls_q.pop_front(), "response");
          check_miss(resp_miss_o, exp_miss_q.pop_front(), "response");
        end
      end
      if (stall_on && !req_ready_o) begin
        drop_seen = 1'b1;
        stall_on = 1'b0;                     // release the stalled response
      end
    end
  end

  // ready level picked at the edge and driven just after it
  always @(posedge clk_i) begin
    if (stall_on) ready_nxt = 1'b0;
    else if (bp_on) ready_nxt = logic'($urandom % 2);
    else ready_nxt = 1'b1;
    #1 resp_ready_i = ready_nxt;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int e0;
    addr_t x;
    stat_count_t n_miss;
    void'($urandom(17848));
    {clk_i, req_v_i, req_sigext_i, resp_ready_i} = '0;
    {req_size_i, req_mask_i, req_addr_i, stat_sel_i} = '0;
    req_op_i = OP_LD;
    {stall_on, bp_on, drop_seen} = '0;
    {cycles, errors, checks} = '0;
    do_reset();

    e0 = errors;
    repeat (60) send_rand(1'b1);
    drain();
    test_done("classification", e0);

    e0 = errors;
    x = 12'h0C8;                             // tag 3 in set 1
    send_req(OP_LD, 2'd2, 1'b0, 4'h0, x);
    send_req(OP_LD, 2'd2, 1'b0, 4'h0, x);
    send_req(OP_AINV, 2'd0, 1'b0, 4'h0, 12'h048);   // same set with another tag
    send_req(OP_LD, 2'd1, 1'b1, 4'h0, x);
    send_req(OP_AINV, 2'd0, 1'b0, 4'h0, x);
    send_req(OP_LD, 2'd0, 1'b0, 4'h0, x);
    send_req(OP_ST, 2'd2, 1'b0, 4'hF, x);
    send_req(OP_TAGFL, 2'd0, 1'b0, 4'h0, 12'h000);
    send_req(OP_LD, 2'd2, 1'b0, 4'h0, x);
    repeat (40) send_rand(1'b0);
    drain();
    test_done("hit/miss", e0);

    e0 = errors;
    bp_on = 1'b1;
    repeat (40) send_rand(1'b0);
    drain();
    stall_on = 1'b1;                         // pipe is empty here
    repeat (12) send_rand(1'b0);
    drain();
    bp_on = 1'b0;
    if (!drop_seen) begin
      errors++;
      $display("req_ready_o never dropped while the response was stalled");
    end
    test_done("back-pressure", e0);

    e0 = errors;
    check_events();
    test_done("event counters", e0);

    e0 = errors;
    check_cycles();
    test_done("cycle counters", e0);

    e0 = errors;
    @(posedge clk_i);
    #1 do_reset();
    check_events();
    check_cycles();
    for (int i = 0; i < 8; i++) begin
      x = addr_t'((($urandom % 4) << 6) | (i << 3) | ($urandom % 8));
      send_req(i[0] ? OP_ST : OP_LD, 2'd2, 1'b0, 4'hF, x);
    end
    drain();
    stat_sel_i = STAT_MISS_LD;
    #1 n_miss = stat_o;
    stat_sel_i = STAT_MISS_ST;
    #1 n_miss = n_miss + stat_o;
    check_count(n_miss, 32'd8, "misses after reset");
    test_done("reset", e0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: vcache_profiled.f
logic/vcache_pkg.sv
logic/vcache_req_if.sv
logic/vcache_mon_if.sv
logic/vcache_req_decode.sv
logic/vcache_req_fifo.sv
logic/vcache_tag_stage.sv
logic/vcache_profiler.sv
logic/vcache_profiled.sv
tests/vcache_profiled_tb.sv
